// File: flist.f
+incdir+source
source/l2req_pkg.sv
source/l2arb_pkg.sv
source/l2req_slot.sv
source/request_arbiter.sv
source/l2req_arbiter_mux.sv
source/l2_credit_counter.sv
source/l2req_top.sv
tb/l2req_properties.sv
tb/l2req_tb.sv

// File: Makefile
TOP := l2req_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f $(wildcard source/*.sv source/*.svh tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

# The simulator's exit status is ignored, the log decides pass or fail
run: obj_dir/V$(TOP)
	-obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/l2req_tb.sv
// Testbench for the L2 request port with random traffic, arbiter prediction and credit checks
`default_nettype none
`include "l2_cfg.svh"

module l2req_tb;

	localparam int field_width = `STRAND_INDEX_WIDTH + 2 + 3 + 2 + 26 + `CACHE_LINE_BYTES * 9;
	localparam int strand_width = `STRAND_INDEX_WIDTH;
	localparam int random_cycles = 400;
	localparam int rotate_cycles = 60;
	localparam int stall_cycles = 20;
	localparam int hold_cycles = 30;
	localparam int stimulus_cycles = random_cycles + rotate_cycles + stall_cycles + hold_cycles;
	localparam int timeout_cycles = 8 * stimulus_cycles + 200;
	localparam int ph_idle = 0;
	localparam int ph_random = 1;
	localparam int ph_rotate = 2;
	localparam int ph_stall = 3;
	localparam int ph_hold = 4;
	localparam int ph_drain = 5;

	logic                                clk;
	logic                                reset;
	logic [2:0]                          req_valid;
	logic [2:0]                          req_ready;
	logic [`STRAND_INDEX_WIDTH - 1:0]    req_strand [3];
	l2req_pkg::l2_unit_t                 req_unit [3];
	l2req_pkg::l2_op_t                   req_op [3];
	logic [1:0]                          req_way [3];
	logic [25:0]                         req_address [3];
	logic [`CACHE_LINE_BYTES * 8 - 1:0]  req_data [3];
	logic [`CACHE_LINE_BYTES - 1:0]      req_mask [3];
	logic                                l2req_valid;
	logic                                l2req_ready;
	logic [`STRAND_INDEX_WIDTH - 1:0]    l2req_strand;
	l2req_pkg::l2_unit_t                 l2req_unit;
	l2req_pkg::l2_op_t                   l2req_op;
	logic [1:0]                          l2req_way;
	logic [25:0]                         l2req_address;
	logic [`CACHE_LINE_BYTES * 8 - 1:0]  l2req_data;
	logic [`CACHE_LINE_BYTES - 1:0]      l2req_mask;
	logic                                l2_response;

	logic [31:0]                         lcg_state;
	int                                  phase;
	int                                  cycle_count;
	int                                  error_count;
	int                                  outstanding;
	int                                  hold_issues;
	int                                  resp_wait [$];
	// Requests accepted by each slot and not yet issued, oldest first
	logic [field_width - 1:0]            sent [3][$];
	l2arb_pkg::requester_t               model_pointer;
	l2arb_pkg::requester_t               last_issued;

	l2req_top uut (
		.clk(clk), .reset(reset),
		.icache_l2req_valid(req_valid[0]), .icache_l2req_ready(req_ready[0]),
		.icache_l2req_strand(req_strand[0]), .icache_l2req_unit(req_unit[0]),
		.icache_l2req_op(req_op[0]), .icache_l2req_way(req_way[0]),
		.icache_l2req_address(req_address[0]), .icache_l2req_data(req_data[0]),
		.icache_l2req_mask(req_mask[0]),
		.dcache_l2req_valid(req_valid[1]), .dcache_l2req_ready(req_ready[1]),
		.dcache_l2req_strand(req_strand[1]), .dcache_l2req_unit(req_unit[1]),
		.dcache_l2req_op(req_op[1]), .dcache_l2req_way(req_way[1]),
		.dcache_l2req_address(req_address[1]), .dcache_l2req_data(req_data[1]),
		.dcache_l2req_mask(req_mask[1]),
		.stbuf_l2req_valid(req_valid[2]), .stbuf_l2req_ready(req_ready[2]),
		.stbuf_l2req_strand(req_strand[2]), .stbuf_l2req_unit(req_unit[2]),
		.stbuf_l2req_op(req_op[2]), .stbuf_l2req_way(req_way[2]),
		.stbuf_l2req_address(req_address[2]), .stbuf_l2req_data(req_data[2]),
		.stbuf_l2req_mask(req_mask[2]),
		.l2req_valid(l2req_valid), .l2req_ready(l2req_ready),
		.l2req_strand(l2req_strand), .l2req_unit(l2req_unit), .l2req_op(l2req_op),
		.l2req_way(l2req_way), .l2req_address(l2req_address),
		.l2req_data(l2req_data), .l2req_mask(l2req_mask),
		.l2_response(l2_response)
	);

	// Low bits of an LCG repeat quickly, so only the upper half is handed out
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {16'd0, lcg_state[31:16]};
	endfunction

	// First pending requester at or after the pointer, wrapping around
	function automatic l2arb_pkg::requester_t predict_grant(input logic [2:0] pending,
		input l2arb_pkg::requester_t pointer);
		int idx;
		for (int i = 0; i < 3; i++)
		begin
			idx = (int'(pointer) + i) % 3;
			if (pending[idx])
				return l2arb_pkg::requester_t'(idx);
		end
		return l2arb_pkg::req_icache;
	endfunction

	function automatic logic want_request();
		if (phase == ph_random)
			return (next_random() % 8) < 5;
		return phase == ph_rotate || phase == ph_stall || phase == ph_hold;
	endfunction

	task automatic check_value(input logic [255:0] actual, input logic [255:0] expected,
		input string what);
		if (actual !== expected)
		begin
			error_count++;
			$display("FAIL t=%0t: %s mismatch, got %0h expected %0h",
				$time, what, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic drive_request(input int r);
		logic [`CACHE_LINE_BYTES * 8 - 1:0] line;
		line = '0;
		for (int k = 0; k < `CACHE_LINE_BYTES / 2; k++)
			line = {line[`CACHE_LINE_BYTES * 8 - 17:0], 16'(next_random())};
		req_valid[r] <= 1'b1;
		req_strand[r] <= strand_width'(next_random());
		req_unit[r] <= l2req_pkg::l2_unit_t'(2'(next_random()));
		req_op[r] <= l2req_pkg::l2_op_t'(3'(next_random() % 6));
		req_way[r] <= 2'(next_random());
		req_address[r] <= {10'(next_random()), 16'(next_random())};
		req_data[r] <= line;
		req_mask[r] <= 16'(next_random());
	endtask

	// Returns once every accepted request has issued and every credit is back
	task automatic wait_idle();
		do
			@(negedge clk);
		while (sent[0].size() != 0 || sent[1].size() != 0 || sent[2].size() != 0
			|| outstanding != 0 || req_valid != 3'b000 || resp_wait.size() != 0);
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// Requesters, L2 back-pressure and the L2 response model
	always @(posedge clk)
	begin
		int due;
		logic pulse;

		for (int r = 0; r < 3; r++)
		begin
			if (!req_valid[r] || req_ready[r])
			begin
				if (want_request())
					drive_request(r);
				else
					req_valid[r] <= 1'b0;
			end
		end
		if (phase == ph_random)
			l2req_ready <= (next_random() % 4) != 0;
		else
			l2req_ready <= phase != ph_stall;

		foreach (resp_wait[i])
			if (resp_wait[i] > 0)
				resp_wait[i]--;
		due = -1;
		pulse = 1'b0;
		foreach (resp_wait[i])
			if (due < 0 && resp_wait[i] == 0)
				due = i;
		if (due >= 0 && phase != ph_hold)
		begin
			resp_wait.delete(due);
			pulse = 1'b1;
		end
		l2_response <= pulse;
		if (l2req_valid && l2req_ready)
			resp_wait.push_back(1 + int'(next_random() % 6));
	end

	// Compares the port against the reference model on every edge
	always @(posedge clk)
	begin
		logic [2:0] pend;
		l2arb_pkg::requester_t pred;
		logic exp_valid;
		logic issue;

		if (!reset)
		begin
			for (int r = 0; r < 3; r++)
				pend[r] = sent[r].size() != 0;
			pred = predict_grant(pend, model_pointer);
			exp_valid = pend != 3'b000 && outstanding < `L2_CREDITS;
			issue = exp_valid && l2req_ready;
			check_value(l2req_valid, exp_valid, "l2req_valid");
			check_value(uut.credit_counter.count, outstanding, "outstanding count");
			for (int r = 0; r < 3; r++)
				check_value(req_ready[r], !pend[r] || (issue && int'(pred) == r), "ready");
			if (exp_valid)
				check_value({l2req_strand, l2req_unit, l2req_op, l2req_way, l2req_address,
					l2req_data, l2req_mask}, sent[pred][0], "issued request");
			if (issue)
			begin
				if (phase == ph_rotate && pend == 3'b111)
					check_value(uut.arbiter_mux.grant_index, (int'(last_issued) + 1) % 3,
						"rotation order");
				void'(sent[pred].pop_front());
				model_pointer = l2arb_pkg::requester_t'((int'(pred) + 1) % 3);
				last_issued = pred;
				outstanding++;
				if (phase == ph_hold)
					hold_issues++;
			end
			if (l2_response)
				outstanding--;
			for (int r = 0; r < 3; r++)
				if (req_valid[r] && req_ready[r])
					sent[r].push_back({req_strand[r], req_unit[r], req_op[r], req_way[r],
						req_address[r], req_data[r], req_mask[r]});
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Run timed out after %0d cycles", cycle_count);
			$display("CHECKS FAILED");
			$fatal(1, "Timeout");
		end
	end

	initial
	begin
		lcg_state = 32'h202f;
		phase = ph_idle;
		cycle_count = 0;
		error_count = 0;
		outstanding = 0;
		hold_issues = 0;
		model_pointer = l2arb_pkg::req_icache;
		last_issued = l2arb_pkg::req_stbuf;
		reset = 1'b1;
		req_valid = 3'b000;
		l2req_ready = 1'b0;
		l2_response = 1'b0;
		for (int r = 0; r < 3; r++)
		begin
			req_strand[r] = '0;
			req_unit[r] = l2req_pkg::unit_icache;
			req_op[r] = l2req_pkg::op_load;
			req_way[r] = '0;
			req_address[r] = '0;
			req_data[r] = '0;
			req_mask[r] = '0;
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_value(l2req_valid, 1'b0, "l2req_valid after reset");
		check_value(req_ready, 3'b111, "ready after reset");

		phase <= ph_random;
		repeat (random_cycles) @(posedge clk);
		phase <= ph_rotate;
		repeat (rotate_cycles) @(posedge clk);
		phase <= ph_stall;
		repeat (stall_cycles) @(posedge clk);
		phase <= ph_drain;
		wait_idle();

		// Start with every credit free so the limit is reached exactly
		hold_issues = 0;
		@(posedge clk);
		phase <= ph_hold;
		repeat (hold_cycles) @(posedge clk);
		@(negedge clk);
		check_value(hold_issues, `L2_CREDITS, "issues with responses withheld");
		@(posedge clk);
		phase <= ph_drain;
		wait_idle();

		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/l2req_properties.sv
// Bound assertions on the arbiter grant and the credit counter limits
`default_nettype none
`include "l2_cfg.svh"

module l2req_properties
#(
	parameter bit on_arbiter = 1'b0
)
(
	input  wire logic                                    clk,
	input  wire logic                                    reset,
	input  wire logic [l2arb_pkg::num_requesters - 1:0]  grant,
	input  wire logic [$clog2(`L2_CREDITS + 1) - 1:0]    count,
	input  wire logic                                    valid
);

	localparam logic [$clog2(`L2_CREDITS + 1) - 1:0] limit = `L2_CREDITS;

	// Each instance watches only the block it is bound to
	if (on_arbiter)
	begin : grant_checks
		grant_one_hot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
			else $error("Arbiter grant has more than one bit set");
	end
	else
	begin : credit_checks
		count_in_range: assert property (@(posedge clk) disable iff (reset) count <= limit)
			else $error("Credit count is above the credit limit");

		// No request may be offered once every credit is in use
		no_valid_at_limit: assert property (@(posedge clk) disable iff (reset)
			(count == limit) |-> !valid)
			else $error("l2req_valid is high with no credit free");
	end

endmodule

// The arbiter carries no credit signals
bind request_arbiter l2req_properties #(.on_arbiter(1'b1)) arbiter_props (
	.clk(clk), .reset(reset), .grant(grant),
	.count('0), .valid(1'b0)
);

bind l2_credit_counter l2req_properties #(.on_arbiter(1'b0)) credit_props (
	.clk(clk), .reset(reset), .grant(3'b000),
	.count(count), .valid(l2req_valid)
);

`default_nettype wire

// File: source/l2req_top.sv
// L2 request port top level: requester arbitration with credit-gated issue
`default_nettype none
`include "l2_cfg.svh"

module l2req_top
(
	input  wire logic                               clk,
	input  wire logic                               reset,
	input  wire logic                               icache_l2req_valid,
	output logic                                    icache_l2req_ready,
	input  wire logic [`STRAND_INDEX_WIDTH - 1:0]   icache_l2req_strand,
	input  wire l2req_pkg::l2_unit_t                icache_l2req_unit,
	input  wire l2req_pkg::l2_op_t                  icache_l2req_op,
	input  wire logic [1:0]                         icache_l2req_way,
	input  wire logic [25:0]                        icache_l2req_address,
	input  wire logic [`CACHE_LINE_BYTES * 8 - 1:0] icache_l2req_data,
	input  wire logic [`CACHE_LINE_BYTES - 1:0]     icache_l2req_mask,
	input  wire logic                               dcache_l2req_valid,
	output logic                                    dcache_l2req_ready,
	input  wire logic [`STRAND_INDEX_WIDTH - 1:0]   dcache_l2req_strand,
	input  wire l2req_pkg::l2_unit_t                dcache_l2req_unit,
	input  wire l2req_pkg::l2_op_t                  dcache_l2req_op,
	input  wire logic [1:0]                         dcache_l2req_way,
	input  wire logic [25:0]                        dcache_l2req_address,
	input  wire logic [`CACHE_LINE_BYTES * 8 - 1:0] dcache_l2req_data,
	input  wire logic [`CACHE_LINE_BYTES - 1:0]     dcache_l2req_mask,
	input  wire logic                               stbuf_l2req_valid,
	output logic                                    stbuf_l2req_ready,
	input  wire logic [`STRAND_INDEX_WIDTH - 1:0]   stbuf_l2req_strand,
	input  wire l2req_pkg::l2_unit_t                stbuf_l2req_unit,
	input  wire l2req_pkg::l2_op_t                  stbuf_l2req_op,
	input  wire logic [1:0]                         stbuf_l2req_way,
	input  wire logic [25:0]                        stbuf_l2req_address,
	input  wire logic [`CACHE_LINE_BYTES * 8 - 1:0] stbuf_l2req_data,
	input  wire logic [`CACHE_LINE_BYTES - 1:0]     stbuf_l2req_mask,
	output logic                                    l2req_valid,
	input  wire logic                               l2req_ready,
	output logic [`STRAND_INDEX_WIDTH - 1:0]        l2req_strand,
	output l2req_pkg::l2_unit_t                     l2req_unit,
	output l2req_pkg::l2_op_t                       l2req_op,
	output logic [1:0]                              l2req_way,
	output logic [25:0]                             l2req_address,
	output logic [`CACHE_LINE_BYTES * 8 - 1:0]      l2req_data,
	output logic [`CACHE_LINE_BYTES - 1:0]          l2req_mask,
	input  wire logic                               l2_response
);

	logic any_pending;
	logic issue;

	l2req_arbiter_mux arbiter_mux (
		.clk(clk), .reset(reset),
		.icache_l2req_valid(icache_l2req_valid), .icache_l2req_ready(icache_l2req_ready),
		.icache_l2req_strand(icache_l2req_strand), .icache_l2req_unit(icache_l2req_unit),
		.icache_l2req_op(icache_l2req_op), .icache_l2req_way(icache_l2req_way),
		.icache_l2req_address(icache_l2req_address), .icache_l2req_data(icache_l2req_data),
		.icache_l2req_mask(icache_l2req_mask),
		.dcache_l2req_valid(dcache_l2req_valid), .dcache_l2req_ready(dcache_l2req_ready),
		.dcache_l2req_strand(dcache_l2req_strand), .dcache_l2req_unit(dcache_l2req_unit),
		.dcache_l2req_op(dcache_l2req_op), .dcache_l2req_way(dcache_l2req_way),
		.dcache_l2req_address(dcache_l2req_address), .dcache_l2req_data(dcache_l2req_data),
		.dcache_l2req_mask(dcache_l2req_mask),
		.stbuf_l2req_valid(stbuf_l2req_valid), .stbuf_l2req_ready(stbuf_l2req_ready),
		.stbuf_l2req_strand(stbuf_l2req_strand), .stbuf_l2req_unit(stbuf_l2req_unit),
		.stbuf_l2req_op(stbuf_l2req_op), .stbuf_l2req_way(stbuf_l2req_way),
		.stbuf_l2req_address(stbuf_l2req_address), .stbuf_l2req_data(stbuf_l2req_data),
		.stbuf_l2req_mask(stbuf_l2req_mask),
		.issue(issue),
		.any_pending(any_pending),
		.l2req_strand(l2req_strand), .l2req_unit(l2req_unit), .l2req_op(l2req_op),
		.l2req_way(l2req_way), .l2req_address(l2req_address),
		.l2req_data(l2req_data), .l2req_mask(l2req_mask)
	);

	// Issue is fed back so the winning slot empties and the pointer moves
	l2_credit_counter credit_counter (
		.clk(clk),
		.reset(reset),
		.any_pending(any_pending),
		.l2req_ready(l2req_ready),
		.l2_response(l2_response),
		.l2req_valid(l2req_valid),
		.issue(issue)
	);

endmodule

`default_nettype wire

// File: source/l2_credit_counter.sv
// Credit counter that limits requests outstanding at the L2 and gates issue
`default_nettype none
`include "l2_cfg.svh"

module l2_credit_counter
(
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire logic  any_pending,
	input  wire logic  l2req_ready,
	input  wire logic  l2_response,
	output logic       l2req_valid,
	output logic       issue
);

	localparam int count_width = $clog2(`L2_CREDITS + 1);
	localparam logic [count_width - 1:0] credit_limit = count_width'(`L2_CREDITS);

	// Requests sent to the L2 that have not yet been answered
	logic [count_width - 1:0] count;

	assign l2req_valid = any_pending && (count < credit_limit);
	assign issue = l2req_valid && l2req_ready;

	// An issue and a response in the same cycle cancel out
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			count <= '0;
		else if (issue && !l2_response)
			count <= count + 1'b1;
		else if (l2_response && !issue)
			count <= count - 1'b1;
	end

endmodule

`default_nettype wire

// File: source/l2req_arbiter_mux.sv
// Holding slots for the three requesters, arbitration and the shared field mux
`default_nettype none
`include "l2_cfg.svh"

module l2req_arbiter_mux
(
	input  wire logic                               clk,
	input  wire logic                               reset,
	input  wire logic                               icache_l2req_valid,
	output logic                                    icache_l2req_ready,
	input  wire logic [`STRAND_INDEX_WIDTH - 1:0]   icache_l2req_strand,
	input  wire l2req_pkg::l2_unit_t                icache_l2req_unit,
	input  wire l2req_pkg::l2_op_t                  icache_l2req_op,
	input  wire logic [1:0]                         icache_l2req_way,
	input  wire logic [25:0]                        icache_l2req_address,
	input  wire logic [`CACHE_LINE_BYTES * 8 - 1:0] icache_l2req_data,
	input  wire logic [`CACHE_LINE_BYTES - 1:0]     icache_l2req_mask,
	input  wire logic                               dcache_l2req_valid,
	output logic                                    dcache_l2req_ready,
	input  wire logic [`STRAND_INDEX_WIDTH - 1:0]   dcache_l2req_strand,
	input  wire l2req_pkg::l2_unit_t                dcache_l2req_unit,
	input  wire l2req_pkg::l2_op_t                  dcache_l2req_op,
	input  wire logic [1:0]                         dcache_l2req_way,
	input  wire logic [25:0]                        dcache_l2req_address,
	input  wire logic [`CACHE_LINE_BYTES * 8 - 1:0] dcache_l2req_data,
	input  wire logic [`CACHE_LINE_BYTES - 1:0]     dcache_l2req_mask,
	input  wire logic                               stbuf_l2req_valid,
	output logic                                    stbuf_l2req_ready,
	input  wire logic [`STRAND_INDEX_WIDTH - 1:0]   stbuf_l2req_strand,
	input  wire l2req_pkg::l2_unit_t                stbuf_l2req_unit,
	input  wire l2req_pkg::l2_op_t                  stbuf_l2req_op,
	input  wire logic [1:0]                         stbuf_l2req_way,
	input  wire logic [25:0]                        stbuf_l2req_address,
	input  wire logic [`CACHE_LINE_BYTES * 8 - 1:0] stbuf_l2req_data,
	input  wire logic [`CACHE_LINE_BYTES - 1:0]     stbuf_l2req_mask,
	input  wire logic                               issue,
	output logic                                    any_pending,
	output logic [`STRAND_INDEX_WIDTH - 1:0]        l2req_strand,
	output l2req_pkg::l2_unit_t                     l2req_unit,
	output l2req_pkg::l2_op_t                       l2req_op,
	output logic [1:0]                              l2req_way,
	output logic [25:0]                             l2req_address,
	output logic [`CACHE_LINE_BYTES * 8 - 1:0]      l2req_data,
	output logic [`CACHE_LINE_BYTES - 1:0]          l2req_mask
);

	// Index 0 is icache, 1 is dcache and 2 is stbuf, as in requester_t
	logic [2:0]                          pending;
	logic [2:0]                          grant;
	l2arb_pkg::requester_t               grant_index;
	logic [`STRAND_INDEX_WIDTH - 1:0]    held_strand [3];
	l2req_pkg::l2_unit_t                 held_unit [3];
	l2req_pkg::l2_op_t                   held_op [3];
	logic [1:0]                          held_way [3];
	logic [25:0]                         held_address [3];
	logic [`CACHE_LINE_BYTES * 8 - 1:0]  held_data [3];
	logic [`CACHE_LINE_BYTES - 1:0]      held_mask [3];

	l2req_slot icache_slot (
		.clk(clk), .reset(reset),
		.valid(icache_l2req_valid), .ready(icache_l2req_ready),
		.strand(icache_l2req_strand), .unit(icache_l2req_unit), .op(icache_l2req_op),
		.way(icache_l2req_way), .address(icache_l2req_address),
		.data(icache_l2req_data), .mask(icache_l2req_mask),
		.issue_grant(grant[0] && issue), .pending(pending[0]),
		.held_strand(held_strand[0]), .held_unit(held_unit[0]), .held_op(held_op[0]),
		.held_way(held_way[0]), .held_address(held_address[0]),
		.held_data(held_data[0]), .held_mask(held_mask[0])
	);

	l2req_slot dcache_slot (
		.clk(clk), .reset(reset),
		.valid(dcache_l2req_valid), .ready(dcache_l2req_ready),
		.strand(dcache_l2req_strand), .unit(dcache_l2req_unit), .op(dcache_l2req_op),
		.way(dcache_l2req_way), .address(dcache_l2req_address),
		.data(dcache_l2req_data), .mask(dcache_l2req_mask),
		.issue_grant(grant[1] && issue), .pending(pending[1]),
		.held_strand(held_strand[1]), .held_unit(held_unit[1]), .held_op(held_op[1]),
		.held_way(held_way[1]), .held_address(held_address[1]),
		.held_data(held_data[1]), .held_mask(held_mask[1])
	);

	l2req_slot stbuf_slot (
		.clk(clk), .reset(reset),
		.valid(stbuf_l2req_valid), .ready(stbuf_l2req_ready),
		.strand(stbuf_l2req_strand), .unit(stbuf_l2req_unit), .op(stbuf_l2req_op),
		.way(stbuf_l2req_way), .address(stbuf_l2req_address),
		.data(stbuf_l2req_data), .mask(stbuf_l2req_mask),
		.issue_grant(grant[2] && issue), .pending(pending[2]),
		.held_strand(held_strand[2]), .held_unit(held_unit[2]), .held_op(held_op[2]),
		.held_way(held_way[2]), .held_address(held_address[2]),
		.held_data(held_data[2]), .held_mask(held_mask[2])
	);

	// Pointer only rotates when a request actually leaves for the L2
	request_arbiter arbiter (
		.clk(clk),
		.reset(reset),
		.request(pending),
		.advance(issue),
		.grant(grant),
		.grant_index(grant_index)
	);

	// With nothing pending the index rests on icache, and valid is low anyway
	assign l2req_strand = held_strand[grant_index];
	assign l2req_unit = held_unit[grant_index];
	assign l2req_op = held_op[grant_index];
	assign l2req_way = held_way[grant_index];
	assign l2req_address = held_address[grant_index];
	assign l2req_data = held_data[grant_index];
	assign l2req_mask = held_mask[grant_index];

	assign any_pending = |pending;

endmodule

`default_nettype wire

// File: source/request_arbiter.sv
// Rotating-priority arbiter with a one-hot grant and a matching grant index
`default_nettype none

module request_arbiter
(
	input  wire logic                                       clk,
	input  wire logic                                       reset,
	input  wire logic [l2arb_pkg::num_requesters - 1:0]     request,
	input  wire logic                                       advance,
	output logic [l2arb_pkg::num_requesters - 1:0]          grant,
	output l2arb_pkg::requester_t                           grant_index
);

	// Requester that has first claim on the next issue
	l2arb_pkg::requester_t pointer;
	l2arb_pkg::requester_t next_pointer;

	// Search from the pointer upward and wrap, taking the first request seen
	always_comb
	begin
		int idx;
		logic found;

		grant = '0;
		grant_index = l2arb_pkg::req_icache;
		found = 1'b0;
		for (int i = 0; i < l2arb_pkg::num_requesters; i++)
		begin
			idx = (int'(pointer) + i) % l2arb_pkg::num_requesters;
			if (!found && request[idx])
			begin
				found = 1'b1;
				grant[idx] = 1'b1;
				grant_index = l2arb_pkg::requester_t'(idx);
			end
		end
	end

	// The winner drops to lowest priority once its request has gone out
	assign next_pointer = (grant_index == l2arb_pkg::req_stbuf) ? l2arb_pkg::req_icache
		: l2arb_pkg::requester_t'(grant_index + 2'd1);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			pointer <= l2arb_pkg::req_icache;
		else if (advance)
			pointer <= next_pointer;
	end

endmodule

`default_nettype wire

// File: source/l2req_slot.sv
// One-entry holding slot that keeps a requester's request until it issues
`default_nettype none
`include "l2_cfg.svh"

module l2req_slot
(
	input  wire logic                              clk,
	input  wire logic                              reset,
	input  wire logic                              valid,
	output logic                                   ready,
	input  wire logic [`STRAND_INDEX_WIDTH - 1:0]  strand,
	input  wire l2req_pkg::l2_unit_t               unit,
	input  wire l2req_pkg::l2_op_t                 op,
	input  wire logic [1:0]                        way,
	input  wire logic [25:0]                       address,
	input  wire logic [`CACHE_LINE_BYTES * 8 - 1:0] data,
	input  wire logic [`CACHE_LINE_BYTES - 1:0]    mask,
	input  wire logic                              issue_grant,
	output logic                                   pending,
	output logic [`STRAND_INDEX_WIDTH - 1:0]       held_strand,
	output l2req_pkg::l2_unit_t                    held_unit,
	output l2req_pkg::l2_op_t                      held_op,
	output logic [1:0]                             held_way,
	output logic [25:0]                            held_address,
	output logic [`CACHE_LINE_BYTES * 8 - 1:0]     held_data,
	output logic [`CACHE_LINE_BYTES - 1:0]         held_mask
);

	logic transfer;

	// The slot frees up in the cycle its request leaves, so a new one
	// can be taken on the same edge
	assign ready = !pending || issue_grant;
	assign transfer = valid && ready;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			pending <= 1'b0;
		else if (transfer)
			pending <= 1'b1;
		else if (issue_grant)
			pending <= 1'b0;
	end

	// Payload only changes when a request is accepted
	always_ff @(posedge clk)
	begin
		if (transfer)
		begin
			held_strand <= strand;
			held_unit <= unit;
			held_op <= op;
			held_way <= way;
			held_address <= address;
			held_data <= data;
			held_mask <= mask;
		end
	end

endmodule

`default_nettype wire

// File: source/l2arb_pkg.sv
// Arbitration types for the L2 request port: names of the arbitrated inputs
`default_nettype none

package l2arb_pkg;

	localparam int num_requesters = 3;

	// Position of each requester in the request and grant vectors
	typedef enum logic [1:0]
	{
		req_icache = 2'd0,
		req_dcache = 2'd1,
		req_stbuf  = 2'd2
	} requester_t;

endpackage

`default_nettype wire

// File: source/l2req_pkg.sv
// Request field types for the L2 request port: opcodes and issuing units
`default_nettype none

package l2req_pkg;

	// Operation requested from the L2
	typedef enum logic [2:0]
	{
		op_load       = 3'd0,
		op_store      = 3'd1,
		op_flush      = 3'd2,
		op_invalidate = 3'd3,
		op_load_sync  = 3'd4,
		op_store_sync = 3'd5
	} l2_op_t;

	// Cache unit that issued the request
	// The L2 uses this to route the response back
	typedef enum logic [1:0]
	{
		unit_icache = 2'd0,
		unit_dcache = 2'd1,
		unit_stbuf  = 2'd2,
		unit_ext    = 2'd3
	} l2_unit_t;

endpackage

`default_nettype wire

// File: source/l2_cfg.svh
// L2 request port configuration: strand width, line size and credit limit
`ifndef L2_CFG_SVH
`define L2_CFG_SVH

// Width of the strand index carried with every request
`define STRAND_INDEX_WIDTH 2

// Bytes in one cache line
// The data field is eight times this wide and the byte mask matches it
`define CACHE_LINE_BYTES 16

// Requests that may be outstanding at the L2 before issue stalls
`define L2_CREDITS 4

`endif
